//--- run_sim.sh
#!/bin/sh
# Build the fetch stage testbench with Verilator and run it from the project root.
# The exit status is 0 only when the log holds the pass message.

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim_run.log

verilator --binary --timing -f src.f --top-module fetch_stage_tb \
    -Mdir "$BUILD_DIR" -o fetch_stage_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/fetch_stage_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- sim/fetch_stage_tb.sv
/*
 * Testbench for the fetch stage. Every operation and expected value comes from
 * sim/fetch_vectors.txt, so the simulator must run from the project root.
 * Between clock steps the PC is held by stall so AXI traffic cannot move it.
 */

`timescale 1ns/1ps

module fetch_stage_tb;
    import fetch_pkg::*;

    localparam int NAME_BITS   = 8 * 24;    // Test name from the vector file
    localparam int HS_LIMIT    = 16;        // Cycles allowed for a handshake
    localparam int DRIVE_DELAY = 1;

    logic              i_clk;
    logic              i_reset;
    logic [AXI_AW-1:0] i_awaddr;
    logic              i_awvalid;
    logic              o_awready;
    logic [INST_W-1:0] i_wdata;
    logic [3:0]        i_wstrb;
    logic              i_wvalid;
    logic              o_wready;
    logic [1:0]        o_bresp;
    logic              o_bvalid;
    logic              i_bready;
    logic [AXI_AW-1:0] i_araddr;
    logic              i_arvalid;
    logic              o_arready;
    logic [INST_W-1:0] o_rdata;
    logic [1:0]        o_rresp;
    logic              o_rvalid;
    logic              i_rready;
    logic [PC_W-1:0]   i_branch_addr;
    logic [PC_W-1:0]   i_jump_addr;
    logic [PC_W-1:0]   i_jr_addr;
    logic              i_take_branch;
    logic              i_take_jump;
    logic              i_take_jr;
    logic              i_stall;
    logic [PC_W-1:0]   o_pc;
    logic [PC_W-1:0]   o_npc;
    logic [PC_W-1:0]   o_bds;
    logic [INST_W-1:0] o_instruction;

    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;           // Set once the vector file is measured

    fetch_stage #(.MEM_AW(DEF_MEM_AW)) u_dut (.*);

    initial i_clk = 1'b0;
    always #4 i_clk = ~i_clk;               // 8 ns period

    task automatic fail_run(input string why);
        $display("%0s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input logic [NAME_BITS-1:0] test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error [%0s] %0s: expected %h, actual %h",
                     test, field, expected, actual);
            fail_run("Output mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge i_clk);
        #DRIVE_DELAY;
    endtask

    // Clear redirects and raise stall so the PC holds
    task automatic hold_fetch();
        i_take_branch = 1'b0;
        i_take_jump   = 1'b0;
        i_take_jr     = 1'b0;
        i_stall       = 1'b1;
    endtask

    task automatic axi_write(input logic [NAME_BITS-1:0] test, input logic [31:0] addr,
                             input logic [31:0] data, input logic [31:0] exp_resp);
        int waited;
        i_awaddr  = addr[AXI_AW-1:0];
        i_wdata   = data;
        i_awvalid = 1'b1;
        i_wvalid  = 1'b1;
        waited    = 0;
        while (!(o_awready && o_wready)) begin
            if (waited == HS_LIMIT) fail_run("The AXI write address/data handshake hung");
            next_cycle();
            waited++;
        end
        next_cycle();                       // Transfer at this edge
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
        waited    = 0;
        while (!o_bvalid) begin
            if (waited == HS_LIMIT) fail_run("The AXI write response never arrived");
            next_cycle();
            waited++;
        end
        check_value(test, "bresp", exp_resp, 32'(o_bresp));
        i_bready = 1'b1;
        next_cycle();
        i_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [NAME_BITS-1:0] test, input logic [31:0] addr,
                            input logic [31:0] exp_data, input logic [31:0] exp_resp);
        int waited;
        i_araddr  = addr[AXI_AW-1:0];
        i_arvalid = 1'b1;
        waited    = 0;
        while (!o_arready) begin
            if (waited == HS_LIMIT) fail_run("The AXI read address handshake hung");
            next_cycle();
            waited++;
        end
        next_cycle();
        i_arvalid = 1'b0;
        waited    = 0;
        while (!o_rvalid) begin
            if (waited == HS_LIMIT) fail_run("The AXI read data never arrived");
            next_cycle();
            waited++;
        end
        check_value(test, "rdata", exp_data, o_rdata);
        check_value(test, "rresp", exp_resp, 32'(o_rresp));
        i_rready = 1'b1;
        next_cycle();
        i_rready = 1'b0;
    endtask

    // One fetch cycle driven by f[0..6] and checked against f[7..10]
    task automatic clock_step(input logic [NAME_BITS-1:0] test, input logic [31:0] f [0:10]);
        i_take_branch = f[0][0];
        i_take_jump   = f[1][0];
        i_take_jr     = f[2][0];
        i_branch_addr = f[3];
        i_jump_addr   = f[4];
        i_jr_addr     = f[5];
        i_stall       = f[6][0];
        next_cycle();
        check_value(test, "pc", f[7], o_pc);
        check_value(test, "instruction", f[8], o_instruction);
        check_value(test, "npc", f[9], o_npc);
        check_value(test, "bds", f[10], o_bds);
        hold_fetch();
    endtask

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            fail_run($sformatf("Timeout: the run passed its limit of %0d cycles", cycle_limit));
        end
    end

    initial begin
        int          fd;
        int          ch;
        int          code;
        int unsigned lines;
        logic [7:0]  op;
        logic [NAME_BITS-1:0] name;
        logic [31:0] f [0:10];

        i_reset       = 1'b1;
        i_awaddr      = '0;
        i_awvalid     = 1'b0;
        i_wdata       = '0;
        i_wstrb       = 4'hF;
        i_wvalid      = 1'b0;
        i_bready      = 1'b0;
        i_araddr      = '0;
        i_arvalid     = 1'b0;
        i_rready      = 1'b0;
        i_branch_addr = '0;
        i_jump_addr   = '0;
        i_jr_addr     = '0;
        hold_fetch();

        // First pass only counts lines for the cycle limit
        fd = $fopen("sim/fetch_vectors.txt", "r");
        if (fd == 0) fail_run("Cannot open sim/fetch_vectors.txt");
        lines = 0;
        ch    = $fgetc(fd);
        while (ch != -1) begin
            if (ch == 10) lines++;
            ch = $fgetc(fd);
        end
        $fclose(fd);
        cycle_limit = 20 * lines + 100;

        repeat (2) next_cycle();
        i_reset = 1'b0;

        fd   = $fopen("sim/fetch_vectors.txt", "r");
        code = $fscanf(fd, "%s", op);
        while (code == 1) begin
            if (op == "#") begin
                ch = $fgetc(fd);                // Skip the comment line
                while (ch != 10 && ch != -1) ch = $fgetc(fd);
            end else if (op == "W" || op == "R") begin
                code = $fscanf(fd, "%s %h %h %h", name, f[0], f[1], f[2]);
                if (code != 4) fail_run("An AXI line in the vector file is malformed");
                if (op == "W") axi_write(name, f[0], f[1], f[2]);
                else axi_read(name, f[0], f[1], f[2]);
            end else if (op == "C") begin
                code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h", name,
                               f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                               f[7], f[8], f[9], f[10]);
                if (code != 12) fail_run("A clock step line in the vector file is malformed");
                clock_step(name, f);
            end else begin
                fail_run("The vector file holds an unknown opcode");
            end
            code = $fscanf(fd, "%s", op);
        end
        $fclose(fd);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- sim/fetch_vectors.txt
# W/R name addr data resp : AXI write, or read with expected data and response (hex)
# C name take_br take_j take_jr br_addr j_addr jr_addr stall exp_pc exp_instr exp_npc exp_bds
C reset_pc 0 0 0 00000000 00000000 00000000 0 00000000 00000000 00000004 00000008
R reset_ctrl 0 00000000 0
R reset_status 4 00000000 0
W load_addr0 8 00000000 0
W load_w0 c 3c010001 0
W load_w1 c 34210002 0
W load_w2 c 00011020 0
W load_w3 c 10220004 0
W load_w4 c 08000010 0
W load_w5 c 03e00008 0
W load_w6 c 8c430000 0
W load_w7 c ac430004 0
R load_count 8 00000008 0
W load_addr20 8 00000020 0
W load_w20 c 2463fffc 0
R load_count2 8 00000021 0
W run_on 0 00000001 0
R run_readback 0 00000001 0
C seq_1 0 0 0 00000000 00000000 00000000 0 00000004 34210002 00000008 0000000c
C seq_2 0 0 0 00000000 00000000 00000000 0 00000008 00011020 0000000c 00000010
C seq_3 0 0 0 00000000 00000000 00000000 0 0000000c 10220004 00000010 00000014
C branch 1 0 0 00000018 00000000 00000000 0 00000018 8c430000 0000001c 00000020
C branch_jump 1 1 0 00000004 00000080 00000000 0 00000080 2463fffc 00000084 00000088
C all_three 1 1 1 00000004 00000008 00000014 0 00000014 03e00008 00000018 0000001c
C stall_hold 1 1 1 00000000 00000004 00000008 1 00000014 03e00008 00000018 0000001c
C seq_4 0 0 0 00000000 00000000 00000000 0 00000018 8c430000 0000001c 00000020
W refuse_load c deadbeef 2
R refuse_addr 8 00000021 0
C jump_refused 0 1 0 00000000 00000084 00000000 0 00000084 00000000 00000088 0000008c
W status_write 4 12345678 2
W unmapped_write 6 00000001 2
R unmapped_read 2 00000000 2
R imem_data_read c 00000000 0
W run_off 0 00000000 0
C frozen 0 0 0 00000000 00000000 00000000 0 00000084 00000000 00000088 0000008c
R status_frozen 4 00000084 0
R run_cleared 0 00000000 0

//--- source/fetch_csr.sv
/*
 * AXI4-Lite control block for the fetch stage. Full-word writes only.
 * Instruction memory can be loaded only while run is 0; loads while
 * running answer SLVERR and leave memory and the load address alone.
 */

`timescale 1ns/1ps

module fetch_csr #(
    parameter int MEM_AW = fetch_pkg::DEF_MEM_AW
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    // Write address and data
    input  logic [fetch_pkg::AXI_AW-1:0]  i_awaddr,
    input  logic                          i_awvalid,
    output logic                          o_awready,
    input  logic [fetch_pkg::INST_W-1:0]  i_wdata,
    input  logic                          i_wvalid,
    output logic                          o_wready,
    // Write response
    output logic [1:0]                    o_bresp,
    output logic                          o_bvalid,
    input  logic                          i_bready,
    // Read address and data
    input  logic [fetch_pkg::AXI_AW-1:0]  i_araddr,
    input  logic                          i_arvalid,
    output logic                          o_arready,
    output logic [fetch_pkg::INST_W-1:0]  o_rdata,
    output logic [1:0]                    o_rresp,
    output logic                          o_rvalid,
    input  logic                          i_rready,
    // Fetch side
    input  logic [fetch_pkg::PC_W-1:0]    i_pc,
    output logic                          o_run,
    output logic                          o_imem_we,
    output logic [MEM_AW-1:0]             o_imem_waddr,
    output logic [fetch_pkg::INST_W-1:0]  o_imem_wdata
);
    import fetch_pkg::*;

    logic              wr_ready_q;          // Shared AWREADY/WREADY
    logic              bvalid_q;
    logic              rd_ready_q;
    logic              rvalid_q;
    logic              run_q;
    logic [MEM_AW-1:0] imem_addr_q;         // Auto-incrementing load index
    logic              wr_hs;
    logic              rd_hs;
    logic              wr_is_data;
    logic [1:0]        wr_resp;
    logic [1:0]        rd_resp;
    logic [INST_W-1:0] rd_data;

    assign wr_hs      = wr_ready_q && i_awvalid && i_wvalid;
    assign rd_hs      = rd_ready_q && i_arvalid;
    assign wr_is_data = (i_awaddr == REG_IMEM_DATA);

    // Write response per register map
    always_comb begin
        wr_resp = RESP_OKAY;
        case (i_awaddr)
            REG_CTRL:      wr_resp = RESP_OKAY;
            REG_IMEM_ADDR: wr_resp = RESP_OKAY;
            REG_IMEM_DATA: wr_resp = run_q ? RESP_SLVERR : RESP_OKAY;  // Refused while running
            default:       wr_resp = RESP_SLVERR;                     // STATUS and holes
        endcase
    end

    // Read mux with the PC sampled at accept
    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (i_araddr)
            REG_CTRL:      rd_data[0] = run_q;
            REG_STATUS:    rd_data = i_pc;
            REG_IMEM_ADDR: rd_data[MEM_AW-1:0] = imem_addr_q;
            REG_IMEM_DATA: rd_data = '0;                // Write-only port
            default:       rd_resp = RESP_SLVERR;
        endcase
    end

    // Handshake and register state
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ready_q  <= 1'b0;
            bvalid_q    <= 1'b0;
            rd_ready_q  <= 1'b0;
            rvalid_q    <= 1'b0;
            run_q       <= 1'b0;
            imem_addr_q <= '0;
        end else begin
            wr_ready_q <= i_awvalid && i_wvalid && !wr_ready_q && !bvalid_q;
            rd_ready_q <= i_arvalid && !rd_ready_q && !rvalid_q;

            if (wr_hs) begin
                bvalid_q <= 1'b1;
            end else if (i_bready) begin
                bvalid_q <= 1'b0;
            end

            if (rd_hs) begin
                rvalid_q <= 1'b1;
            end else if (i_rready) begin
                rvalid_q <= 1'b0;
            end

            if (wr_hs && i_awaddr == REG_CTRL) begin
                run_q <= i_wdata[0];
            end

            if (wr_hs && i_awaddr == REG_IMEM_ADDR) begin
                imem_addr_q <= i_wdata[MEM_AW-1:0];
            end else if (wr_hs && wr_is_data && !run_q) begin
                imem_addr_q <= imem_addr_q + MEM_AW'(1);    // Wraps at top
            end
        end
    end

    // Response payload
    always_ff @(posedge i_clk) begin
        if (wr_hs) begin
            o_bresp <= wr_resp;
        end
        if (rd_hs) begin
            o_rdata <= rd_data;
            o_rresp <= rd_resp;
        end
    end

    assign o_awready    = wr_ready_q;
    assign o_wready     = wr_ready_q;
    assign o_bvalid     = bvalid_q;
    assign o_arready    = rd_ready_q;
    assign o_rvalid     = rvalid_q;
    assign o_run        = run_q;

    // Memory lands at the handshake edge
    assign o_imem_we    = wr_hs && wr_is_data && !run_q;
    assign o_imem_waddr = imem_addr_q;
    assign o_imem_wdata = i_wdata;

endmodule

//--- source/fetch_pkg.sv
/*
 * Shared widths, the control register map and the AXI4-Lite response codes.
 * Register offsets are byte addresses on a 16-byte window.
 */

package fetch_pkg;

    // Datapath widths
    localparam int INST_W     = 32;                     // One instruction word
    localparam int PC_W       = 32;                     // Byte-addressed PC

    // Instruction store depth, as word-address bits
    localparam int DEF_MEM_AW = 10;                     // 1024 words

    // AXI4-Lite slave
    localparam int AXI_AW     = 4;                      // Four word registers

    localparam logic [AXI_AW-1:0] REG_CTRL      = 4'h0; // Bit 0 is run
    localparam logic [AXI_AW-1:0] REG_STATUS    = 4'h4; // Current PC, read only
    localparam logic [AXI_AW-1:0] REG_IMEM_ADDR = 4'h8; // Load word index
    localparam logic [AXI_AW-1:0] REG_IMEM_DATA = 4'hC; // Load data port

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- source/fetch_redirect_if.sv
/*
 * Redirect bundle from the later stages into the PC unit.
 * Targets arrive fully formed as byte addresses.
 */

`timescale 1ns/1ps

interface fetch_redirect_if;
    import fetch_pkg::*;

    logic [PC_W-1:0] branch_target;     // Taken branch destination
    logic [PC_W-1:0] jump_target;       // J/JAL destination
    logic [PC_W-1:0] jr_target;         // GPR[rs] for JR/JALR
    logic            take_branch;
    logic            take_jump;
    logic            take_jr;
    logic            stall;             // Hazard hold

    modport source (
        output branch_target, jump_target, jr_target,
        output take_branch, take_jump, take_jr, stall
    );

    modport sink (
        input branch_target, jump_target, jr_target,
        input take_branch, take_jump, take_jr, stall
    );

endinterface

//--- source/fetch_stage.sv
/*
 * Instruction fetch stage with its AXI4-Lite control block.
 * MEM_AW may range from 4 to 14. Write strobes are ignored, and
 * instruction memory is loadable only through the control registers.
 */

`timescale 1ns/1ps

module fetch_stage #(
    parameter int MEM_AW = fetch_pkg::DEF_MEM_AW
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    // AXI4-Lite slave
    input  logic [fetch_pkg::AXI_AW-1:0]  i_awaddr,
    input  logic                          i_awvalid,
    output logic                          o_awready,
    input  logic [fetch_pkg::INST_W-1:0]  i_wdata,
    input  logic [3:0]                    i_wstrb,     // Full-word writes only
    input  logic                          i_wvalid,
    output logic                          o_wready,
    output logic [1:0]                    o_bresp,
    output logic                          o_bvalid,
    input  logic                          i_bready,
    input  logic [fetch_pkg::AXI_AW-1:0]  i_araddr,
    input  logic                          i_arvalid,
    output logic                          o_arready,
    output logic [fetch_pkg::INST_W-1:0]  o_rdata,
    output logic [1:0]                    o_rresp,
    output logic                          o_rvalid,
    input  logic                          i_rready,
    // Redirects from decode and hazard unit
    input  logic [fetch_pkg::PC_W-1:0]    i_branch_addr,
    input  logic [fetch_pkg::PC_W-1:0]    i_jump_addr,
    input  logic [fetch_pkg::PC_W-1:0]    i_jr_addr,
    input  logic                          i_take_branch,
    input  logic                          i_take_jump,
    input  logic                          i_take_jr,
    input  logic                          i_stall,
    // To decode
    output logic [fetch_pkg::PC_W-1:0]    o_pc,
    output logic [fetch_pkg::PC_W-1:0]    o_npc,
    output logic [fetch_pkg::PC_W-1:0]    o_bds,
    output logic [fetch_pkg::INST_W-1:0]  o_instruction
);
    import fetch_pkg::*;

    logic              run;
    logic [PC_W-1:0]   pc;
    logic              imem_we;
    logic [MEM_AW-1:0] imem_waddr;
    logic [INST_W-1:0] imem_wdata;

    fetch_redirect_if redirect ();

    assign redirect.branch_target = i_branch_addr;
    assign redirect.jump_target   = i_jump_addr;
    assign redirect.jr_target     = i_jr_addr;
    assign redirect.take_branch   = i_take_branch;
    assign redirect.take_jump     = i_take_jump;
    assign redirect.take_jr       = i_take_jr;
    assign redirect.stall         = i_stall;

    fetch_csr #(.MEM_AW(MEM_AW)) u_csr (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
        .i_wdata(i_wdata), .i_wvalid(i_wvalid), .o_wready(o_wready),
        .o_bresp(o_bresp), .o_bvalid(o_bvalid), .i_bready(i_bready),
        .i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
        .o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid), .i_rready(i_rready),
        .i_pc(pc), .o_run(run),
        .o_imem_we(imem_we), .o_imem_waddr(imem_waddr), .o_imem_wdata(imem_wdata)
    );

    pc_unit u_pc (
        .i_clk(i_clk), .i_reset(i_reset), .i_run(run),
        .i_redirect(redirect.sink),
        .o_pc(pc), .o_npc(o_npc), .o_bds(o_bds)
    );

    instruction_mem #(.MEM_AW(MEM_AW)) u_imem (
        .i_clk(i_clk), .i_we(imem_we),
        .i_waddr(imem_waddr), .i_wdata(imem_wdata),
        .i_pc(pc), .o_instruction(o_instruction)
    );

    assign o_pc = pc;

endmodule

//--- source/instruction_mem.sv
/*
 * Word-organized instruction store. Read is asynchronous by PC[MEM_AW+1:2],
 * write is synchronous. Contents start at zero in simulation only.
 */

`timescale 1ns/1ps

module instruction_mem #(
    parameter int MEM_AW = fetch_pkg::DEF_MEM_AW
) (
    input  logic                          i_clk,
    input  logic                          i_we,
    input  logic [MEM_AW-1:0]             i_waddr,
    input  logic [fetch_pkg::INST_W-1:0]  i_wdata,
    input  logic [fetch_pkg::PC_W-1:0]    i_pc,
    output logic [fetch_pkg::INST_W-1:0]  o_instruction
);
    import fetch_pkg::*;

    localparam int DEPTH = 1 << MEM_AW;

    logic [INST_W-1:0] mem [0:DEPTH-1];
    logic [MEM_AW-1:0] raddr;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Byte PC to word index, upper bits ignored
    assign raddr         = i_pc[MEM_AW+1:2];
    assign o_instruction = mem[raddr];

endmodule

//--- source/pc_unit.sv
/*
 * Program counter with fixed-priority next-PC select: jr, jump, branch,
 * then PC+4. Updates only when running and not stalled. Resets to 0.
 */

`timescale 1ns/1ps

module pc_unit (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_run,
    fetch_redirect_if.sink              i_redirect,
    output logic [fetch_pkg::PC_W-1:0]  o_pc,
    output logic [fetch_pkg::PC_W-1:0]  o_npc,
    output logic [fetch_pkg::PC_W-1:0]  o_bds
);
    import fetch_pkg::*;

    logic [PC_W-1:0] pc_q;
    logic [PC_W-1:0] pc_plus4;
    logic [PC_W-1:0] pc_next;
    logic            pc_en;

    assign pc_plus4 = pc_q + PC_W'(4);

    // Highest priority first
    always_comb begin
        if (i_redirect.take_jr) begin
            pc_next = i_redirect.jr_target;
        end else if (i_redirect.take_jump) begin
            pc_next = i_redirect.jump_target;
        end else if (i_redirect.take_branch) begin
            pc_next = i_redirect.branch_target;
        end else begin
            pc_next = pc_plus4;             // Sequential
        end
    end

    assign pc_en = i_run && !i_redirect.stall;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc_q <= '0;
        end else if (pc_en) begin
            pc_q <= pc_next;
        end
    end

    assign o_pc  = pc_q;
    assign o_npc = pc_plus4;                // Link value seen by decode
    assign o_bds = pc_q + PC_W'(8);         // Delay-slot successor

endmodule

//--- src.f
source/fetch_pkg.sv
source/fetch_redirect_if.sv
source/fetch_csr.sv
source/pc_unit.sv
source/instruction_mem.sv
source/fetch_stage.sv
sim/fetch_stage_tb.sv
